/* tb.f */
verilog/vic_pkg.sv
verilog/vic_cfg_if.sv
verilog/vic_bus_clock.sv
verilog/vic_regs.sv
verilog/vic_raster.sv
verilog/vic_fetch.sv
verilog/vic_top.sv
testbench/vic_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the video controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f tb.f --top-module vic_tb -o vic_sim

sim_out=$(./obj_dir/vic_sim)
echo "$sim_out"

if grep -q "^RESULT: PASS$" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

/* testbench/vic_tb.sv */
// Testbench for the raster video controller
// Directed tests over the CPU bus, an SRAM model answering the fetch
// port, frame-wide pixel comparison and a watchdog
`timescale 1ns/10ps

module vic_tb;
  import vic_pkg::*;

  // ======================================================================
  // Frame geometry and timing
  // ======================================================================
  localparam int H_TOTAL      = 64;
  localparam int V_TOTAL      = 40;
  localparam int H_DISP_START = 16;
  localparam int COLS         = 5;
  localparam int V_DISP_START = 8;
  localparam int ROWS         = 3;
  localparam int CLK_DIV      = 8;
  localparam int H_DISP_END   = H_DISP_START + COLS * CELL_W;
  localparam int V_DISP_END   = V_DISP_START + ROWS * CELL_W;
  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 8;
  localparam int RAM_WORDS    = 1 << RAM_ADDR_W;
  localparam int FRAME_CLKS   = H_TOTAL * V_TOTAL;
  // Worst case is about eight frames of waiting plus the bus traffic
  localparam int WATCHDOG_CLKS = 10 * FRAME_CLKS + 400 * CLK_DIV;
  // One status poll per bus cycle covers a frame in this many reads
  localparam int POLL_LIMIT = FRAME_CLKS / CLK_DIV + 8;

  logic       clk;
  logic       rst;
  logic       phi02;
  logic       cs_n;
  logic       rw;
  reg_addr_t  ad;
  logic [7:0] wr_data;
  logic [7:0] rd_data;
  logic       rd_en;
  logic       irq;
  logic       ram_ce;
  logic       ram_oe;
  ram_addr_t  ram_ad;
  logic [7:0] ram_db;
  logic       hsync;
  logic       vsync;
  color_t     color;

  logic [7:0] sram [0:RAM_WORDS-1];
  integer     seed;
  int         err_count;
  int         check_count_total;
  int         test_count;
  int         test_err_start;

  // Register settings mirrored for the pixel model
  logic   exp_den;
  int     exp_vbase;
  int     exp_cbase;
  color_t exp_border;
  color_t exp_background;
  color_t exp_fg;

  vic_top #(
    .H_TOTAL      (H_TOTAL),
    .V_TOTAL      (V_TOTAL),
    .H_DISP_START (H_DISP_START),
    .COLS         (COLS),
    .V_DISP_START (V_DISP_START),
    .ROWS         (ROWS),
    .CLK_DIV      (CLK_DIV)
  ) dut_i (
    .clk     (clk),
    .rst     (rst),
    .phi02   (phi02),
    .cs_n    (cs_n),
    .rw      (rw),
    .ad      (ad),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .rd_en   (rd_en),
    .irq     (irq),
    .ram_ce  (ram_ce),
    .ram_oe  (ram_oe),
    .ram_ad  (ram_ad),
    .ram_db  (ram_db),
    .hsync   (hsync),
    .vsync   (vsync),
    .color   (color)
  );

  // Asynchronous SRAM whose data follows the address
  assign ram_db = sram[ram_ad];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CLKS * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  // ======================================================================
  // Compare tasks
  // ======================================================================
  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
    check_count_total++;
    if (got !== exp) begin
      $display("** Error at %0t: %s: got %h, expected %h", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic check_color(input color_t got, input color_t exp, input string msg);
    check_count_total++;
    if (got !== exp) begin
      $display("** Error at %0t: %s: got %h, expected %h", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    check_count_total++;
    if (got !== exp) begin
      $display("** Error at %0t: %s: got %b, expected %b", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string msg);
    check_count_total++;
    if (got != exp) begin
      $display("** Error at %0t: %s: got %0d, expected %0d", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic begin_test;
    test_err_start = err_count;
    test_count++;
  endtask

  task automatic end_test(input string name);
    if (err_count == test_err_start) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, err_count - test_err_start);
    end
  endtask

  // ======================================================================
  // CPU bus driver
  // ======================================================================
  // Drive during the high phase so the write lands where phi02 falls
  task automatic cpu_write(input reg_addr_t addr, input logic [7:0] data);
    @(posedge phi02);
    #DRIVE_DLY;
    cs_n    = 1'b0;
    rw      = 1'b0;
    ad      = addr;
    wr_data = data;
    @(negedge phi02);
    #DRIVE_DLY;
    cs_n = 1'b1;
    rw   = 1'b1;
  endtask

  task automatic cpu_read(input reg_addr_t addr, output logic [7:0] data);
    @(posedge phi02);
    #DRIVE_DLY;
    cs_n = 1'b0;
    rw   = 1'b1;
    ad   = addr;
    // Sample one clk into the high phase
    @(posedge clk);
    #DRIVE_DLY;
    check_bit(rd_en, 1'b1, "rd_en during read");
    data = rd_data;
    @(negedge phi02);
    #DRIVE_DLY;
    cs_n = 1'b1;
  endtask

  task automatic write_and_check(input reg_addr_t addr, input logic [7:0] data,
                                 input logic [7:0] exp, input string msg);
    logic [7:0] got;
    cpu_write(addr, data);
    cpu_read(addr, got);
    check_byte(got, exp, msg);
  endtask

  task automatic read_and_check(input reg_addr_t addr, input logic [7:0] exp,
                                input string msg);
    logic [7:0] got;
    cpu_read(addr, got);
    check_byte(got, exp, msg);
  endtask

  // ======================================================================
  // Pixel model
  // ======================================================================
  // Colour expected for count h of line v from the SRAM contents
  function automatic color_t pixel_expected(input int h, input int v);
    int         c;
    int         r;
    int         x;
    int         y;
    ram_addr_t  scr_ad;
    ram_addr_t  pat_ad;
    logic [7:0] code;
    logic [7:0] pat;
    if (!exp_den || h < H_DISP_START || h >= H_DISP_END ||
        v < V_DISP_START || v >= V_DISP_END) begin
      return exp_border;
    end
    c = (h - H_DISP_START) / CELL_W;
    x = (h - H_DISP_START) % CELL_W;
    r = (v - V_DISP_START) / CELL_W;
    y = (v - V_DISP_START) % CELL_W;
    scr_ad = ram_addr_t'(exp_vbase * 1024 + r * COLS + c);
    code   = sram[scr_ad];
    pat_ad = ram_addr_t'(exp_cbase * 2048 + int'(code) * CELL_W + y);
    pat    = sram[pat_ad];
    // Leftmost pixel comes from bit 7
    return pat[7 - x] ? exp_fg : exp_background;
  endfunction

  // SRAM read strobe expected at count h of line v
  // Each cell is fetched in the 8 counts before it is shown
  function automatic logic read_expected(input int h, input int v);
    int slot;
    if (!exp_den || v < V_DISP_START || v >= V_DISP_END ||
        h < H_DISP_START - CELL_W || h >= H_DISP_END - CELL_W) begin
      return 1'b0;
    end
    // Screen code read at offset 0 and pattern read at offset 2
    slot = (h - (H_DISP_START - CELL_W)) % CELL_W;
    return (slot == 0) || (slot == 2);
  endfunction

  // After the vsync rise the outputs show count 0 of line 0
  // The SRAM strobes follow the counters one count ahead of color
  task automatic scan_frame;
    int   n;
    logic rd_exp;
    @(posedge vsync);
    #DRIVE_DLY;
    for (int v = 0; v < V_TOTAL; v++) begin
      for (int h = 0; h < H_TOTAL; h++) begin
        n      = (v * H_TOTAL + h + 1) % FRAME_CLKS;
        rd_exp = read_expected(n % H_TOTAL, n / H_TOTAL);
        check_color(color, pixel_expected(h, v), $sformatf("pixel %0d,%0d", h, v));
        check_bit(ram_ce, rd_exp, $sformatf("ram_ce at count %0d", n));
        check_bit(ram_oe, rd_exp, $sformatf("ram_oe at count %0d", n));
        @(posedge clk);
        #DRIVE_DLY;
      end
    end
  endtask

  // ======================================================================
  // Tests
  // ======================================================================
  task automatic test_reset_state;
    logic [7:0] data;
    begin_test();
    check_bit(irq, 1'b0, "irq in reset");
    check_bit(ram_ce, 1'b0, "ram_ce in reset");
    check_bit(ram_oe, 1'b0, "ram_oe in reset");
    check_bit(rd_en, 1'b0, "rd_en in reset");
    check_bit(phi02, 1'b0, "phi02 in reset");
    check_bit(hsync, 1'b0, "hsync in reset");
    check_bit(vsync, 1'b0, "vsync in reset");
    check_color(color, 4'h0, "color in reset");
    rst = 1'b0;
    cpu_read(REG_CTRL1, data);
    check_byte(data, 8'h00, "CTRL1 after reset");
    cpu_read(REG_MEMPTR, data);
    check_byte(data, 8'h00, "MEMPTR after reset");
    cpu_read(REG_IRQ_ENABLE, data);
    check_byte(data, 8'h00, "IRQ_ENABLE after reset");
    cpu_read(REG_BORDER, data);
    check_byte(data, 8'h00, "BORDER after reset");
    cpu_read(REG_BACKGROUND, data);
    check_byte(data, 8'h00, "BACKGROUND after reset");
    cpu_read(REG_CHAR_COLOR, data);
    check_byte(data, 8'h00, "CHAR_COLOR after reset");
    // Compare resets to line 0, which matches as soon as counting starts
    cpu_read(REG_IRQ_STATUS, data);
    check_byte(data, 8'h01, "IRQ_STATUS after reset");
    check_bit(irq, 1'b0, "irq with enable off");
    cpu_read(6'h00, data);
    check_byte(data, 8'hFF, "unused offset 0x00");
    cpu_read(6'h3F, data);
    check_byte(data, 8'hFF, "unused offset 0x3F");
    end_test("reset state");
  endtask

  task automatic test_register_access;
    begin_test();
    write_and_check(REG_BORDER, 8'h0B, 8'h0B, "BORDER readback");
    write_and_check(REG_BACKGROUND, 8'h05, 8'h05, "BACKGROUND readback");
    write_and_check(REG_CHAR_COLOR, 8'h0C, 8'h0C, "CHAR_COLOR readback");
    write_and_check(REG_MEMPTR, 8'hA6, 8'hA6, "MEMPTR readback");
    write_and_check(REG_IRQ_ENABLE, 8'h01, 8'h01, "IRQ_ENABLE readback");
    write_and_check(REG_IRQ_ENABLE, 8'h00, 8'h00, "IRQ_ENABLE cleared");
    write_and_check(REG_CTRL1, 8'h90, 8'h90, "CTRL1 readback");
    write_and_check(REG_CTRL1, 8'h00, 8'h00, "CTRL1 cleared");
    // Unused offsets swallow the write and leave the registers alone
    write_and_check(6'h00, 8'h55, 8'hFF, "unused 0x00 after write");
    write_and_check(6'h3F, 8'h55, 8'hFF, "unused 0x3F after write");
    write_and_check(6'h23, 8'h07, 8'hFF, "unused 0x23 after write");
    read_and_check(REG_BORDER, 8'h0B, "BORDER after unused writes");
    read_and_check(REG_BACKGROUND, 8'h05, "BACKGROUND after unused writes");
    read_and_check(REG_CHAR_COLOR, 8'h0C, "CHAR_COLOR after unused writes");
    read_and_check(REG_MEMPTR, 8'hA6, "MEMPTR after unused writes");
    read_and_check(REG_CTRL1, 8'h00, "CTRL1 after unused writes");
    read_and_check(REG_IRQ_ENABLE, 8'h00, "IRQ_ENABLE after unused writes");
    end_test("register access");
  endtask

  task automatic test_sync_timing;
    time        t0;
    time        t1;
    logic [7:0] l1;
    logic [7:0] l2;
    begin_test();
    @(posedge phi02);
    t0 = $time;
    @(negedge phi02);
    t1 = $time;
    check_count(int'((t1 - t0) / CLK_PERIOD), CLK_DIV / 2, "phi02 high time in clk");
    @(posedge phi02);
    t1 = $time;
    check_count(int'((t1 - t0) / CLK_PERIOD), CLK_DIV, "phi02 period in clk");
    @(posedge hsync);
    t0 = $time;
    @(negedge hsync);
    t1 = $time;
    check_count(int'((t1 - t0) / CLK_PERIOD), 4, "hsync width in clk");
    @(posedge hsync);
    t1 = $time;
    check_count(int'((t1 - t0) / CLK_PERIOD), H_TOTAL, "hsync period in clk");
    @(posedge vsync);
    t0 = $time;
    @(posedge vsync);
    t1 = $time;
    check_count(int'((t1 - t0) / CLK_PERIOD), FRAME_CLKS, "vsync period in clk");
    // The frame has just started so the line three lines on is higher
    cpu_read(REG_RASTER, l1);
    repeat (3 * H_TOTAL) @(posedge clk);
    cpu_read(REG_RASTER, l2);
    check_bit(int'(l1) < V_TOTAL, 1'b1, "first line below V_TOTAL");
    check_bit(int'(l2) < V_TOTAL, 1'b1, "second line below V_TOTAL");
    check_bit(l2 > l1, 1'b1, "raster line increasing");
    end_test("sync timing");
  endtask

  task automatic test_raster_irq;
    logic [7:0] data;
    int         polls;
    int         waited;
    begin_test();
    cpu_write(REG_CTRL1, 8'h00);
    cpu_write(REG_RASTER, 8'd20);
    cpu_write(REG_IRQ_ENABLE, 8'h00);
    cpu_write(REG_IRQ_STATUS, 8'h01);
    data  = 8'h00;
    polls = 0;
    while (!data[0] && polls < POLL_LIMIT) begin
      cpu_read(REG_IRQ_STATUS, data);
      polls++;
    end
    if (!data[0]) begin
      $display("Raster compare at line 20 never set the status bit");
      err_count++;
    end else begin
      cpu_read(REG_RASTER, data);
      check_byte(data, 8'd20, "line at compare event");
      check_bit(irq, 1'b0, "irq with enable off");
      cpu_write(REG_IRQ_ENABLE, 8'h01);
      check_bit(irq, 1'b1, "irq after enable");
      cpu_write(REG_IRQ_STATUS, 8'h01);
      check_bit(irq, 1'b0, "irq after status clear");
      waited = 0;
      while (!irq && waited < FRAME_CLKS + H_TOTAL) begin
        @(posedge clk);
        #DRIVE_DLY;
        waited++;
      end
      if (!irq) begin
        $display("irq did not rise again on the next frame");
        err_count++;
      end else begin
        cpu_read(REG_RASTER, data);
        check_byte(data, 8'd20, "line at second interrupt");
      end
    end
    cpu_write(REG_IRQ_ENABLE, 8'h00);
    cpu_write(REG_IRQ_STATUS, 8'h01);
    end_test("raster interrupt");
  endtask

  task automatic test_border_only;
    begin_test();
    exp_den        = 1'b0;
    exp_border     = 4'hA;
    exp_background = 4'h3;
    cpu_write(REG_CTRL1, 8'h00);
    cpu_write(REG_BORDER, {4'h0, exp_border});
    cpu_write(REG_BACKGROUND, {4'h0, exp_background});
    scan_frame();
    end_test("border with display off");
  endtask

  task automatic test_char_render;
    begin_test();
    exp_den        = 1'b1;
    exp_vbase      = 3;
    exp_cbase      = 5;
    exp_border     = 4'h6;
    exp_background = 4'h1;
    exp_fg         = 4'hE;
    // Matrix base in the upper nibble and character base in bits 3:1
    cpu_write(REG_MEMPTR, {4'(exp_vbase), 3'(exp_cbase), 1'b0});
    cpu_write(REG_BORDER, {4'h0, exp_border});
    cpu_write(REG_BACKGROUND, {4'h0, exp_background});
    cpu_write(REG_CHAR_COLOR, {4'h0, exp_fg});
    cpu_write(REG_CTRL1, 8'h10);
    scan_frame();
    end_test("character rendering");
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    int i;
    seed    = 32'h0bde_ee9a;
    rst     = 1'b1;
    cs_n    = 1'b1;
    rw      = 1'b1;
    ad      = '0;
    wr_data = 8'h00;
    err_count         = 0;
    check_count_total = 0;
    test_count        = 0;
    exp_den        = 1'b0;
    exp_vbase      = 0;
    exp_cbase      = 0;
    exp_border     = 4'h0;
    exp_background = 4'h0;
    exp_fg         = 4'h0;
    for (i = 0; i < RAM_WORDS; i++) begin
      sram[i] = 8'($random(seed));
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    test_reset_state();
    test_register_access();
    test_sync_timing();
    test_raster_irq();
    test_border_only();
    test_char_render();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count_total, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog/vic_top.sv */
// Raster video controller top level
// Text-mode video chip with phased CPU bus, raster interrupt and
// byte-wide SRAM fetch; frame size set by the parameters below
`timescale 1ns/10ps

module vic_top #(
  parameter int H_TOTAL      = 64,
  parameter int V_TOTAL      = 40,
  parameter int H_DISP_START = 16,
  parameter int COLS         = 5,
  parameter int V_DISP_START = 8,
  parameter int ROWS         = 3,
  parameter int CLK_DIV      = 8
) (
  input  logic               clk,
  input  logic               rst,
  output logic               phi02,
  input  logic               cs_n,
  input  logic               rw,
  input  vic_pkg::reg_addr_t ad,
  input  logic [7:0]         wr_data,
  output logic [7:0]         rd_data,
  output logic               rd_en,
  output logic               irq,
  output logic               ram_ce,
  output logic               ram_oe,
  output vic_pkg::ram_addr_t ram_ad,
  input  logic [7:0]         ram_db,
  output logic               hsync,
  output logic               vsync,
  output vic_pkg::color_t    color
);

  logic       bus_end;
  logic       in_disp_h;
  logic       in_disp_v;
  logic [2:0] cell_col;
  logic [1:0] cell_row;
  logic [2:0] cell_line;
  logic [2:0] hpos;

  // Settings and raster events between the blocks
  vic_cfg_if cfg ();

  vic_bus_clock #(
    .CLK_DIV (CLK_DIV)
  ) bus_clock_i (
    .clk     (clk),
    .rst     (rst),
    .phi02   (phi02),
    .bus_end (bus_end)
  );

  vic_regs regs_i (
    .clk     (clk),
    .rst     (rst),
    .bus_end (bus_end),
    .phi02   (phi02),
    .cs_n    (cs_n),
    .rw      (rw),
    .ad      (ad),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .rd_en   (rd_en),
    .irq     (irq),
    .cfg     (cfg.regs)
  );

  // Sync outputs leave here registered, aligned with color
  vic_raster #(
    .H_TOTAL      (H_TOTAL),
    .V_TOTAL      (V_TOTAL),
    .H_DISP_START (H_DISP_START),
    .COLS         (COLS),
    .V_DISP_START (V_DISP_START),
    .ROWS         (ROWS)
  ) raster_i (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg.raster),
    .hsync     (hsync),
    .vsync     (vsync),
    .in_disp_h (in_disp_h),
    .in_disp_v (in_disp_v),
    .cell_col  (cell_col),
    .cell_row  (cell_row),
    .cell_line (cell_line),
    .hpos      (hpos)
  );

  vic_fetch #(
    .COLS (COLS)
  ) fetch_i (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg.fetch),
    .in_disp_h (in_disp_h),
    .in_disp_v (in_disp_v),
    .cell_col  (cell_col),
    .cell_row  (cell_row),
    .cell_line (cell_line),
    .hpos      (hpos),
    .ram_ce    (ram_ce),
    .ram_oe    (ram_oe),
    .ram_ad    (ram_ad),
    .ram_db    (ram_db),
    .color     (color)
  );

endmodule

/* verilog/vic_fetch.sv */
// Character fetch and pixel output
// Reads the screen code and pattern byte for the next cell from SRAM,
// loads the pattern shifter and registers one colour index per clk
`timescale 1ns/10ps

module vic_fetch #(
  parameter int COLS = 5
) (
  input  logic               clk,
  input  logic               rst,
  vic_cfg_if.fetch           cfg,
  input  logic               in_disp_h,
  input  logic               in_disp_v,
  input  logic [2:0]         cell_col,
  input  logic [1:0]         cell_row,
  input  logic [2:0]         cell_line,
  input  logic [2:0]         hpos,
  output logic               ram_ce,
  output logic               ram_oe,
  output vic_pkg::ram_addr_t ram_ad,
  input  logic [7:0]         ram_db,
  output vic_pkg::color_t    color
);
  import vic_pkg::*;

  localparam logic [2:0] COLS_C = 3'(COLS);

  // Offsets within the 8-clk cell slot
  localparam logic [2:0] SLOT_SCREEN  = 3'd0;
  localparam logic [2:0] SLOT_PATTERN = 3'd2;
  localparam logic [2:0] SLOT_LOAD    = 3'd7;

  logic       fetch_act;
  logic       rd_screen;
  logic       rd_pattern;
  ram_addr_t  screen_addr;
  ram_addr_t  pattern_addr;
  logic [7:0] code_q;
  logic [7:0] pat_q;
  logic [7:0] shifter;

  // ======================================================================
  // SRAM read sequencing
  // ======================================================================
  // Valid cell column only inside the fetch window
  assign fetch_act  = in_disp_v && (cell_col < COLS_C);
  assign rd_screen  = fetch_act && cfg.den && (hpos == SLOT_SCREEN);
  assign rd_pattern = fetch_act && cfg.den && (hpos == SLOT_PATTERN);

  // Matrix base plus row * COLS + column
  assign screen_addr = {cfg.video_base, 10'd0}
                     + ram_addr_t'(cell_row) * ram_addr_t'(COLS)
                     + ram_addr_t'(cell_col);

  // Character base plus code * 8 plus line within the cell
  assign pattern_addr = {cfg.char_base, 11'd0}
                      + {3'b0, code_q, 3'b0}
                      + ram_addr_t'(cell_line);

  assign ram_ce = rd_screen || rd_pattern;
  assign ram_oe = rd_screen || rd_pattern;
  assign ram_ad = (hpos == SLOT_PATTERN) ? pattern_addr : screen_addr;

  // Async SRAM, data sampled on the same edge that ends the read
  always_ff @(posedge clk) begin
    if (rd_screen) begin
      code_q <= ram_db;
    end
    if (rd_pattern) begin
      pat_q <= ram_db;
    end
  end

  // ======================================================================
  // Pattern shifter
  // ======================================================================
  // Load in the last clk of the previous cell, MSB is pixel 0
  always_ff @(posedge clk) begin
    if (fetch_act && (hpos == SLOT_LOAD)) begin
      shifter <= pat_q;
    end else begin
      shifter <= {shifter[6:0], 1'b0};
    end
  end

  // ======================================================================
  // Colour select, one registered stage
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      color <= '0;
    end else if (cfg.den && in_disp_h && in_disp_v) begin
      color <= shifter[7] ? cfg.char_color : cfg.background;
    end else begin
      color <= cfg.border;
    end
  end

endmodule

/* verilog/vic_raster.sv */
// Raster timing
// Pixel and line counters, registered sync levels, display window
// flags, fetch cell coordinates and the raster compare event
`timescale 1ns/10ps

module vic_raster #(
  parameter int H_TOTAL      = 64,
  parameter int V_TOTAL      = 40,
  parameter int H_DISP_START = 16,
  parameter int COLS         = 5,
  parameter int V_DISP_START = 8,
  parameter int ROWS         = 3
) (
  input  logic       clk,
  input  logic       rst,
  vic_cfg_if.raster  cfg,
  output logic       hsync,
  output logic       vsync,
  output logic       in_disp_h,
  output logic       in_disp_v,
  output logic [2:0] cell_col,
  output logic [1:0] cell_row,
  output logic [2:0] cell_line,
  output logic [2:0] hpos
);
  import vic_pkg::*;

  localparam int HW = $clog2(H_TOTAL);
  // Sync pulse lengths in counts and lines
  localparam int HSYNC_LEN = 4;
  localparam int VSYNC_LEN = 2;

  // Horizontal marks, fetch runs one cell ahead of display
  localparam logic [HW-1:0] H_LAST      = HW'(H_TOTAL - 1);
  localparam logic [HW-1:0] DISP_FIRST  = HW'(H_DISP_START);
  localparam logic [HW-1:0] DISP_END    = HW'(H_DISP_START + COLS * CELL_W);
  localparam logic [HW-1:0] FETCH_FIRST = HW'(H_DISP_START - CELL_W);
  localparam logic [HW-1:0] FETCH_END   = HW'(H_DISP_START + (COLS - 1) * CELL_W);
  // Vertical marks
  localparam raster_t V_LAST      = raster_t'(V_TOTAL - 1);
  localparam raster_t VDISP_FIRST = raster_t'(V_DISP_START);
  localparam raster_t VDISP_END   = raster_t'(V_DISP_START + ROWS * CELL_W);

  logic [HW-1:0] hcnt;
  raster_t       vcnt;
  logic [HW-1:0] hrel;
  raster_t       vrel;
  logic          fetch_win;

  // ======================================================================
  // Counters, advance every clk
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (hcnt == H_LAST) begin
      hcnt <= '0;
      vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 1'b1;
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  // Sync levels and compare event, one clk behind the counters
  always_ff @(posedge clk) begin
    if (rst) begin
      hsync          <= 1'b0;
      vsync          <= 1'b0;
      cfg.raster_hit <= 1'b0;
    end else begin
      hsync          <= (hcnt < HW'(HSYNC_LEN));
      vsync          <= (vcnt < raster_t'(VSYNC_LEN));
      cfg.raster_hit <= (hcnt == '0) && (vcnt == cfg.raster_cmp);
    end
  end

  assign cfg.line = vcnt;

  // ======================================================================
  // Window flags and cell coordinates
  // ======================================================================
  assign in_disp_h = (hcnt >= DISP_FIRST) && (hcnt < DISP_END);
  assign in_disp_v = (vcnt >= VDISP_FIRST) && (vcnt < VDISP_END);
  assign fetch_win = (hcnt >= FETCH_FIRST) && (hcnt < FETCH_END);

  assign hrel = hcnt - FETCH_FIRST;
  assign vrel = vcnt - VDISP_FIRST;

  // All ones outside the fetch window marks "no cell"
  assign cell_col  = fetch_win ? 3'(hrel >> 3) : 3'b111;
  assign hpos      = hrel[2:0];
  assign cell_row  = vrel[4:3];
  assign cell_line = vrel[2:0];

endmodule

/* verilog/vic_regs.sv */
// CPU-visible register file
// Latches bus writes at the end of phi02, drives the read mux and
// keeps the raster interrupt status and enable
`timescale 1ns/10ps

module vic_regs (
  input  logic              clk,
  input  logic              rst,
  input  logic              bus_end,
  input  logic              phi02,
  input  logic              cs_n,
  input  logic              rw,
  input  vic_pkg::reg_addr_t ad,
  input  logic [7:0]        wr_data,
  output logic [7:0]        rd_data,
  output logic              rd_en,
  output logic              irq,
  vic_cfg_if.regs           cfg
);
  import vic_pkg::*;

  // ======================================================================
  // Register storage
  // ======================================================================
  logic [7:0] ctrl1;
  logic [7:0] raster_lo;
  logic [7:0] memptr;
  logic       irq_status;
  logic       irq_en;
  color_t     border_q;
  color_t     background_q;
  color_t     char_color_q;

  logic wr_stb;

  // Write strobe on the clk edge where phi02 falls
  assign wr_stb = bus_end && !cs_n && !rw;

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl1        <= '0;
      raster_lo    <= '0;
      memptr       <= '0;
      irq_status   <= 1'b0;
      irq_en       <= 1'b0;
      border_q     <= '0;
      background_q <= '0;
      char_color_q <= '0;
    end else begin
      if (wr_stb) begin
        case (ad)
          REG_CTRL1:      ctrl1        <= wr_data;
          REG_RASTER:     raster_lo    <= wr_data;
          REG_MEMPTR:     memptr       <= wr_data;
          REG_IRQ_ENABLE: irq_en       <= wr_data[0];
          REG_BORDER:     border_q     <= wr_data[3:0];
          REG_BACKGROUND: background_q <= wr_data[3:0];
          REG_CHAR_COLOR: char_color_q <= wr_data[3:0];
          // Status is handled below, unused offsets drop the write
          default: ;
        endcase
      end
      // A new raster event wins over a clear in the same clk
      if (cfg.raster_hit) begin
        irq_status <= 1'b1;
      end else if (wr_stb && (ad == REG_IRQ_STATUS) && wr_data[0]) begin
        irq_status <= 1'b0;
      end
    end
  end

  // Interrupt level, status gated by enable
  assign irq = irq_status & irq_en;

  // ======================================================================
  // Settings out to the timing and fetch blocks
  // ======================================================================
  assign cfg.den        = ctrl1[CTRL1_DEN_BIT];
  assign cfg.raster_cmp = {ctrl1[CTRL1_RC8_BIT], raster_lo};
  // Upper nibble is the matrix base, bits 3:1 the character base
  assign cfg.video_base = memptr[7:4];
  assign cfg.char_base  = memptr[3:1];
  assign cfg.border     = border_q;
  assign cfg.background = background_q;
  assign cfg.char_color = char_color_q;

  // ======================================================================
  // Read side
  // ======================================================================
  assign rd_en = phi02 && !cs_n && rw;

  always_comb begin
    case (ad)
      REG_CTRL1:      rd_data = ctrl1;
      // Live line, not the compare value
      REG_RASTER:     rd_data = cfg.line[7:0];
      REG_MEMPTR:     rd_data = memptr;
      REG_IRQ_STATUS: rd_data = {7'b0, irq_status};
      REG_IRQ_ENABLE: rd_data = {7'b0, irq_en};
      REG_BORDER:     rd_data = {4'b0, border_q};
      REG_BACKGROUND: rd_data = {4'b0, background_q};
      REG_CHAR_COLOR: rd_data = {4'b0, char_color_q};
      default:        rd_data = UNUSED_READ;
    endcase
  end

endmodule

/* verilog/vic_bus_clock.sv */
// CPU bus phase generator
// Divides clk down to the phi02 bus clock and flags the last clk of
// each bus cycle, where the register file accepts writes
`timescale 1ns/10ps

module vic_bus_clock #(
  parameter int CLK_DIV = 8
) (
  input  logic clk,
  input  logic rst,
  output logic phi02,
  output logic bus_end
);

  // Half period in clk, phi02 toggles at the end of each half
  localparam int HALF = CLK_DIV / 2;
  localparam int CW   = (HALF > 1) ? $clog2(HALF) : 1;

  logic [CW-1:0] half_cnt;
  logic          half_last;

  assign half_last = (half_cnt == CW'(HALF - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      half_cnt <= '0;
      // Bus cycle starts in the low phase
      phi02    <= 1'b0;
    end else if (half_last) begin
      half_cnt <= '0;
      phi02    <= ~phi02;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // High in the last clk of the high phase, so the next edge is the fall
  assign bus_end = phi02 && half_last;

endmodule

/* verilog/vic_cfg_if.sv */
// Internal configuration and raster event bundle
// Carries register settings out of the register file and
// the live raster line and compare event back into it
`timescale 1ns/10ps

interface vic_cfg_if;
  import vic_pkg::*;

  // Settings from the register file
  logic    den;
  raster_t raster_cmp;
  vbase_t  video_base;
  cbase_t  char_base;
  color_t  border;
  color_t  background;
  color_t  char_color;

  // Raster state from the timing block
  raster_t line;
  logic    raster_hit;

  modport regs (
    output den, raster_cmp, video_base, char_base, border, background, char_color,
    input  line, raster_hit
  );

  modport raster (
    input  raster_cmp,
    output line, raster_hit
  );

  modport fetch (
    input den, video_base, char_base, border, background, char_color
  );

endinterface

/* verilog/vic_pkg.sv */
// Shared definitions for the raster video controller
// Register offsets, field widths and the common data types
package vic_pkg;

  // ======================================================================
  // Field widths
  // ======================================================================
  localparam int REG_ADDR_W = 6;
  localparam int COLOR_W    = 4;
  localparam int RASTER_W   = 9;
  localparam int RAM_ADDR_W = 14;
  // Video matrix base in 1 KiB units, character base in 2 KiB units
  localparam int VBASE_W    = 4;
  localparam int CBASE_W    = 3;

  // Pixel width and height of one character cell
  localparam int CELL_W = 8;

  // ======================================================================
  // Types
  // ======================================================================
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [COLOR_W-1:0]    color_t;
  typedef logic [RASTER_W-1:0]   raster_t;
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
  typedef logic [VBASE_W-1:0]    vbase_t;
  typedef logic [CBASE_W-1:0]    cbase_t;

  // ======================================================================
  // Register offsets
  // ======================================================================
  localparam reg_addr_t REG_CTRL1      = 6'h11;
  localparam reg_addr_t REG_RASTER     = 6'h12;
  localparam reg_addr_t REG_MEMPTR     = 6'h18;
  localparam reg_addr_t REG_IRQ_STATUS = 6'h19;
  localparam reg_addr_t REG_IRQ_ENABLE = 6'h1A;
  localparam reg_addr_t REG_BORDER     = 6'h20;
  localparam reg_addr_t REG_BACKGROUND = 6'h21;
  localparam reg_addr_t REG_CHAR_COLOR = 6'h22;

  // Control register 1 bit positions
  localparam int CTRL1_DEN_BIT = 4;
  localparam int CTRL1_RC8_BIT = 7;

  // Value returned for an offset with no register behind it
  localparam logic [7:0] UNUSED_READ = 8'hFF;

endpackage
